/* common/xgio_cfg.svh */
/*
 * Address map codes and sizing for the xgio peripheral block.
 * Include in any module that decodes addresses or sizes the timer or FIFO.
 */
`ifndef XGIO_CFG_SVH
`define XGIO_CFG_SVH

// Peripheral region, address bits 31:28
`define XGIO_REGION         4'h2

// Page codes, address bits 15:12
`define XGIO_PAGE_SYS       4'h0
`define XGIO_PAGE_DISPLAY   4'h1
`define XGIO_PAGE_KBD       4'h5
`define XGIO_PAGE_SD        4'h6

// Register offsets inside a page
`define XGIO_OFS_STATUS     12'h000
`define XGIO_OFS_CODE       12'h004

// Timer period in clock cycles, kept short for simulation
`define XGIO_TIMER_RELOAD   40

// Keyboard FIFO address width, 4 entries
`define XGIO_KBD_DEPTH_LOG2 2

`endif

/* common/xgio_pkg.sv */
/*
 * Shared types of the xgio peripheral block: the Wishbone request,
 * the decoded register access and the timer interrupt states.
 */
package xgio_pkg;

    // Wishbone classic master request
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // Register hit by a decoded address
    typedef enum logic [2:0] {
        REG_NONE,
        REG_SYS,
        REG_DISPLAY,
        REG_KBD_STATUS,
        REG_KBD_CODE,
        REG_SD
    } io_reg_e;

    // One decoded access, valid for a single cycle
    typedef struct packed {
        logic        valid;
        logic        we;
        io_reg_e     regsel;
        logic [31:0] wdata;
    } io_access_t;

    // Timer interrupt handshake
    typedef enum logic [1:0] {
        IRQ_IDLE,
        IRQ_RAISED,
        IRQ_HANDLING
    } irq_state_e;

endpackage

/* kbd/kbd_fifo.sv */
/*
 * Keyboard scan code FIFO. Codes enqueue on strobe unless full; a
 * dequeue pops the head into the code register read by the processor.
 */
`timescale 1ns/1ps
`include "xgio_cfg.svh"

module kbd_fifo (
    input  logic       clk,
    input  logic       reset_i,
    input  logic [7:0] code_i,
    input  logic       strobe_i,
    input  logic       deq_i,
    output logic       not_empty_o,
    output logic [7:0] code_o
);
    localparam int unsigned AW    = `XGIO_KBD_DEPTH_LOG2;
    localparam int unsigned DEPTH = 1 << AW;

    logic [7:0]  mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          enq;
    logic          pop;

    assign full        = (count == (AW+1)'(DEPTH));
    assign not_empty_o = (count != '0);
    // Codes arriving while full are dropped
    assign enq         = strobe_i && !full;
    assign pop         = deq_i && not_empty_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({enq, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and head capture
    always_ff @(posedge clk) begin
        if (enq) begin
            mem[wr_ptr] <= code_i;
        end
        if (pop) begin
            code_o <= mem[rd_ptr];
        end
    end

endmodule

/* src/io_decode.sv */
/*
 * Wishbone classic front end. Turns each bus cycle into a one-cycle
 * decoded access and acknowledges it on the following edge.
 */
`timescale 1ns/1ps
`include "xgio_cfg.svh"

module io_decode (
    input  logic                 clk,
    input  logic                 reset_i,
    input  xgio_pkg::wb_req_t    wb_req_i,
    output logic                 ack_o,
    output xgio_pkg::io_access_t access_o
);
    import xgio_pkg::*;

    logic        start;
    logic        in_region;
    logic [3:0]  page;
    logic [11:0] offset;
    io_reg_e     regsel;

    // New access only while no acknowledge is pending
    assign start     = wb_req_i.cyc && wb_req_i.stb && !ack_o;
    assign in_region = (wb_req_i.adr[31:28] == `XGIO_REGION);
    assign page      = wb_req_i.adr[15:12];
    assign offset    = wb_req_i.adr[11:0];

    always_comb begin
        regsel = REG_NONE;
        if (in_region) begin
            case (page)
                `XGIO_PAGE_SYS: begin
                    if (offset == `XGIO_OFS_STATUS) begin
                        regsel = REG_SYS;
                    end
                end
                // Display answers on the whole page
                `XGIO_PAGE_DISPLAY: regsel = REG_DISPLAY;
                `XGIO_PAGE_KBD: begin
                    if (offset == `XGIO_OFS_STATUS) begin
                        regsel = REG_KBD_STATUS;
                    end else if (offset == `XGIO_OFS_CODE) begin
                        regsel = REG_KBD_CODE;
                    end
                end
                `XGIO_PAGE_SD: begin
                    if (offset == `XGIO_OFS_STATUS) begin
                        regsel = REG_SD;
                    end
                end
                default: regsel = REG_NONE;
            endcase
        end
    end

    always_comb begin
        access_o.valid  = start;
        access_o.we     = wb_req_i.we;
        access_o.regsel = regsel;
        access_o.wdata  = wb_req_i.dat;
    end

    // Every address is acknowledged, one cycle per access
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= start;
        end
    end

endmodule

/* src/io_execute.sv */
/*
 * Write side of the register file. Holds the display byte, the SD pins
 * and the timer enable, and issues keyboard dequeue and lost-clear pulses.
 */
`timescale 1ns/1ps

module io_execute (
    input  logic                 clk,
    input  logic                 reset_i,
    input  xgio_pkg::io_access_t access_i,
    output logic [7:0]           display_o,
    output logic                 sd_sclk_o,
    output logic                 sd_csn_o,
    output logic                 sd_mosi_o,
    output logic                 timer_ena_o,
    output logic                 lost_clr_o,
    output logic                 kbd_deq_o
);
    import xgio_pkg::*;

    logic wr;

    assign wr = access_i.valid && access_i.we;

    // Lands on the acknowledging edge together with the other writes
    assign lost_clr_o = wr && (access_i.regsel == REG_SYS);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_o   <= 8'd0;
            sd_sclk_o   <= 1'b0;
            sd_csn_o    <= 1'b1;
            sd_mosi_o   <= 1'b0;
            timer_ena_o <= 1'b0;
            kbd_deq_o   <= 1'b0;
        end else begin
            // Dequeue request, one cycle wide
            kbd_deq_o <= wr && (access_i.regsel == REG_KBD_STATUS);
            if (wr) begin
                case (access_i.regsel)
                    REG_SYS: timer_ena_o <= access_i.wdata[0];
                    REG_DISPLAY: display_o <= access_i.wdata[7:0];
                    REG_SD: begin
                        // Chip select is written active high
                        sd_sclk_o <= access_i.wdata[2];
                        sd_csn_o  <= ~access_i.wdata[1];
                        sd_mosi_o <= access_i.wdata[0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

/* src/io_result.sv */
/*
 * Read side of the register file. Registers the selected value on a
 * read access so that dat_o is valid alongside the acknowledge.
 */
`timescale 1ns/1ps

module io_result (
    input  logic                 clk,
    input  logic                 reset_i,
    input  xgio_pkg::io_access_t access_i,
    input  logic                 timer_ena_i,
    input  logic                 lost_i,
    input  logic [7:0]           display_i,
    input  logic                 kbd_not_empty_i,
    input  logic [7:0]           kbd_code_i,
    input  logic                 sd_miso_i,
    output logic [31:0]          dat_o
);
    import xgio_pkg::*;

    logic [31:0] rdata;

    always_comb begin
        case (access_i.regsel)
            REG_SYS:        rdata = {30'd0, lost_i, timer_ena_i};
            REG_DISPLAY:    rdata = {24'd0, display_i};
            REG_KBD_STATUS: rdata = {31'd0, kbd_not_empty_i};
            REG_KBD_CODE:   rdata = {24'd0, kbd_code_i};
            REG_SD:         rdata = {31'd0, sd_miso_i};
            // Unmapped reads return zero
            default:        rdata = 32'd0;
        endcase
    end

    // Holds between reads
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dat_o <= 32'd0;
        end else if (access_i.valid && !access_i.we) begin
            dat_o <= rdata;
        end
    end

endmodule

/* src/xgio_top.sv */
/*
 * Top level of the xgio peripheral block, a Wishbone classic slave.
 * Connects the decode, execute and result stages with the timer and keyboard.
 */
`timescale 1ns/1ps

module xgio_top (
    input  logic              clk,
    input  logic              reset_i,
    input  xgio_pkg::wb_req_t wb_req_i,
    input  logic              eoi_i,
    input  logic [7:0]        kbd_code_i,
    input  logic              kbd_strobe_i,
    input  logic              sd_miso_i,
    output logic              ack_o,
    output logic [31:0]       dat_o,
    output logic              irq_o,
    output logic [7:0]        display_o,
    output logic              sd_sclk_o,
    output logic              sd_csn_o,
    output logic              sd_mosi_o
);
    import xgio_pkg::*;

    io_access_t access;
    logic       timer_ena;
    logic       lost_clr;
    logic       lost;
    logic       kbd_deq;
    logic       kbd_not_empty;
    logic [7:0] kbd_code;

    io_decode u_decode (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_req_i (wb_req_i),
        .ack_o    (ack_o),
        .access_o (access)
    );

    io_execute u_execute (
        .clk         (clk),
        .reset_i     (reset_i),
        .access_i    (access),
        .display_o   (display_o),
        .sd_sclk_o   (sd_sclk_o),
        .sd_csn_o    (sd_csn_o),
        .sd_mosi_o   (sd_mosi_o),
        .timer_ena_o (timer_ena),
        .lost_clr_o  (lost_clr),
        .kbd_deq_o   (kbd_deq)
    );

    tick_timer u_timer (
        .clk        (clk),
        .reset_i    (reset_i),
        .ena_i      (timer_ena),
        .eoi_i      (eoi_i),
        .lost_clr_i (lost_clr),
        .irq_o      (irq_o),
        .lost_o     (lost)
    );

    kbd_fifo u_kbd (
        .clk         (clk),
        .reset_i     (reset_i),
        .code_i      (kbd_code_i),
        .strobe_i    (kbd_strobe_i),
        .deq_i       (kbd_deq),
        .not_empty_o (kbd_not_empty),
        .code_o      (kbd_code)
    );

    // Display readback comes from the execute register
    io_result u_result (
        .clk             (clk),
        .reset_i         (reset_i),
        .access_i        (access),
        .timer_ena_i     (timer_ena),
        .lost_i          (lost),
        .display_i       (display_o),
        .kbd_not_empty_i (kbd_not_empty),
        .kbd_code_i      (kbd_code),
        .sd_miso_i       (sd_miso_i),
        .dat_o           (dat_o)
    );

endmodule

/* tb/tb_xgio.sv */
/*
 * Testbench for the xgio Wishbone peripheral block.
 * Drives bus, keyboard, SD and interrupt stimulus and checks with assertions.
 */
`timescale 1ns/1ps
`include "xgio_cfg.svh"

module tb_xgio;
    import xgio_pkg::*;

    localparam int RELOAD = `XGIO_TIMER_RELOAD;
    localparam int DEPTH = 1 << `XGIO_KBD_DEPTH_LOG2;
    localparam int WATCHDOG_CYCLES = 4 * RELOAD * 8 + 2000;
    localparam logic [31:0] ADR_SYS = 32'h2000_0000;
    localparam logic [31:0] ADR_DISPLAY = 32'h2000_1000;
    localparam logic [31:0] ADR_UNMAPPED = 32'h2000_3000;
    localparam logic [31:0] ADR_KBD_STATUS = 32'h2000_5000;
    localparam logic [31:0] ADR_KBD_CODE = 32'h2000_5004;
    localparam logic [31:0] ADR_SD = 32'h2000_6000;

    logic        clk;
    logic        reset_i;
    wb_req_t     wb_req;
    logic        eoi_i;
    logic [7:0]  kbd_code_i;
    logic        kbd_strobe_i;
    logic        sd_miso_i;
    logic        ack_o;
    logic [31:0] dat_o;
    logic        irq_o;
    logic [7:0]  display_o;
    logic        sd_sclk_o;
    logic        sd_csn_o;
    logic        sd_mosi_o;
    int          cyc_count;
    integer      seed;
    logic [7:0]  expq[$];

    xgio_top dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .wb_req_i     (wb_req),
        .eoi_i        (eoi_i),
        .kbd_code_i   (kbd_code_i),
        .kbd_strobe_i (kbd_strobe_i),
        .sd_miso_i    (sd_miso_i),
        .ack_o        (ack_o),
        .dat_o        (dat_o),
        .irq_o        (irq_o),
        .display_o    (display_o),
        .sd_sclk_o    (sd_sclk_o),
        .sd_csn_o     (sd_csn_o),
        .sd_mosi_o    (sd_mosi_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc_count <= cyc_count + 1;
    end

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else stop_on_failure($sformatf("Error: %s expected 0x%0h actual 0x%0h",
                                       name, expected, actual));
    endtask

    // Acknowledge lasts a single cycle
    ack_one_cycle: assert property (@(posedge clk) disable iff (reset_i) ack_o |=> !ack_o)
    else stop_on_failure("Error: ack width expected 0 actual 1");

    // Returns on the falling edge where ack is seen, with the read data
    task automatic run_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.sel = 4'hf;
        wb_req.adr = adr;
        wb_req.dat = wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack_o && waited < 8);
        if (!ack_o) begin
            stop_on_failure("The DUT did not acknowledge a bus access within 8 cycles");
        end else begin
            check_value("ack latency", 1, waited);
            rdata = dat_o;
            wb_req.cyc = 1'b0;
            wb_req.stb = 1'b0;
            wb_req.we  = 1'b0;
        end
    endtask

    task automatic write_reg(input logic [31:0] adr, input logic [31:0] wdata);
        logic [31:0] unused;
        run_access(1'b1, adr, wdata, unused);
    endtask

    task automatic read_reg(input logic [31:0] adr, output logic [31:0] rdata);
        run_access(1'b0, adr, 32'd0, rdata);
    endtask

    task automatic push_code(input logic [7:0] code);
        @(negedge clk);
        kbd_code_i   = code;
        kbd_strobe_i = 1'b1;
        @(negedge clk);
        kbd_strobe_i = 1'b0;
    endtask

    task automatic pop_and_compare(input string name);
        logic [31:0] rd;
        logic [7:0]  exp_code;
        exp_code = expq.pop_front();
        write_reg(ADR_KBD_STATUS, 32'd0);
        read_reg(ADR_KBD_CODE, rd);
        check_value(name, {24'd0, exp_code}, rd);
    endtask

    task automatic wait_for_irq(output int rise_cycle);
        int waited;
        waited = 0;
        check_value("irq low before tick", 0, irq_o);
        while (!irq_o && waited < 2 * RELOAD) begin
            @(negedge clk);
            waited++;
        end
        if (!irq_o) begin
            stop_on_failure("The timer interrupt did not rise within two periods");
        end else begin
            rise_cycle = cyc_count;
        end
    endtask

    // Processor answer, eoi low for two cycles then high
    task automatic complete_eoi();
        @(negedge clk);
        eoi_i = 1'b0;
        repeat (2) @(negedge clk);
        eoi_i = 1'b1;
        @(negedge clk);
        check_value("irq after eoi", 0, irq_o);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_failure("Timeout: the tests did not finish in the expected time");
    end

    initial begin
        logic [31:0] rd;
        logic [7:0]  code;
        int          rise1;
        int          rise2;
        clk = 1'b0;
        reset_i = 1'b1;
        wb_req = '0;
        eoi_i = 1'b1;
        kbd_code_i = 8'd0;
        kbd_strobe_i = 1'b0;
        sd_miso_i = 1'b0;
        cyc_count = 0;
        seed = 70;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // Reset values
        @(negedge clk);
        check_value("reset ack", 0, ack_o);
        check_value("reset irq", 0, irq_o);
        check_value("reset display", 0, display_o);
        check_value("reset sd pins", 3'b010, {sd_sclk_o, sd_csn_o, sd_mosi_o});
        read_reg(ADR_SYS, rd);
        check_value("reset sys", 0, rd);
        read_reg(ADR_KBD_STATUS, rd);
        check_value("reset kbd status", 0, rd);

        // Display and unmapped space
        write_reg(ADR_DISPLAY, 32'h0000_00a5);
        check_value("display write", 8'ha5, display_o);
        read_reg(ADR_DISPLAY, rd);
        check_value("display read", 32'h0000_00a5, rd);
        read_reg(ADR_UNMAPPED, rd);
        check_value("unmapped read", 0, rd);
        write_reg(ADR_UNMAPPED, 32'hffff_ffff);
        check_value("unmapped write display", 8'ha5, display_o);
        check_value("unmapped write sd", 3'b010, {sd_sclk_o, sd_csn_o, sd_mosi_o});

        // SD pins, bit 1 selects the card
        write_reg(ADR_SD, 32'h5);
        check_value("sd pattern 5", 3'b111, {sd_sclk_o, sd_csn_o, sd_mosi_o});
        write_reg(ADR_SD, 32'h2);
        check_value("sd pattern 2", 3'b000, {sd_sclk_o, sd_csn_o, sd_mosi_o});
        sd_miso_i = 1'b1;
        read_reg(ADR_SD, rd);
        check_value("sd miso high", 1, rd);
        sd_miso_i = 1'b0;
        read_reg(ADR_SD, rd);
        check_value("sd miso low", 0, rd);

        // Keyboard FIFO order
        for (int i = 0; i < 3; i++) begin
            code = 8'($random(seed));
            expq.push_back(code);
            push_code(code);
        end
        read_reg(ADR_KBD_STATUS, rd);
        check_value("kbd status not empty", 1, rd);
        for (int i = 0; i < 3; i++) begin
            pop_and_compare("kbd code order");
        end
        read_reg(ADR_KBD_STATUS, rd);
        check_value("kbd status empty", 0, rd);

        // Overflow drops codes beyond the depth
        for (int i = 0; i < 6; i++) begin
            code = 8'($random(seed));
            if (i < DEPTH) begin
                expq.push_back(code);
            end
            push_code(code);
        end
        for (int i = 0; i < DEPTH; i++) begin
            pop_and_compare("kbd overflow order");
        end
        read_reg(ADR_KBD_STATUS, rd);
        check_value("kbd status after overflow", 0, rd);

        // Timer period, IRQ_IDLE to IRQ_RAISED to IRQ_HANDLING
        write_reg(ADR_SYS, 32'h1);
        wait_for_irq(rise1);
        complete_eoi();
        wait_for_irq(rise2);
        check_value("irq period", RELOAD, rise2 - rise1);
        read_reg(ADR_SYS, rd);
        check_value("sys enabled", 1, rd);

        // Hold eoi low across the next tick
        eoi_i = 1'b0;
        while (cyc_count < rise2 + RELOAD + 5) begin
            @(negedge clk);
        end
        read_reg(ADR_SYS, rd);
        check_value("sys lost", 3, rd);
        eoi_i = 1'b1;
        write_reg(ADR_SYS, 32'h0);
        read_reg(ADR_SYS, rd);
        check_value("sys lost cleared", 0, rd);
        repeat (2 * RELOAD) begin
            @(negedge clk);
            check_value("irq disabled", 0, irq_o);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* timer/tick_timer.sv */
/*
 * Periodic timer interrupt. A reload counter raises irq_o and waits for
 * the eoi low-then-high handshake; ticks that cannot be raised set lost_o.
 */
`timescale 1ns/1ps
`include "xgio_cfg.svh"

module tick_timer (
    input  logic clk,
    input  logic reset_i,
    input  logic ena_i,
    input  logic eoi_i,
    input  logic lost_clr_i,
    output logic irq_o,
    output logic lost_o
);
    import xgio_pkg::*;

    localparam int unsigned RELOAD = `XGIO_TIMER_RELOAD;
    localparam int unsigned CNT_W  = $clog2(RELOAD);

    logic [CNT_W-1:0] count;
    logic             tick;
    irq_state_e       state;

    assign tick  = (count == '0);
    assign irq_o = (state != IRQ_IDLE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count  <= CNT_W'(RELOAD - 1);
            state  <= IRQ_IDLE;
            lost_o <= 1'b0;
        end else begin
            count <= tick ? CNT_W'(RELOAD - 1) : count - 1'b1;

            if (lost_clr_i) begin
                lost_o <= 1'b0;
            end

            case (state)
                // Processor acknowledges by pulling eoi low
                IRQ_RAISED: if (!eoi_i) state <= IRQ_HANDLING;
                // irq drops once eoi returns high
                IRQ_HANDLING: if (eoi_i) state <= IRQ_IDLE;
                default: begin
                end
            endcase

            // A tick wins over the handshake transitions above
            if (tick && ena_i) begin
                if (state == IRQ_IDLE && eoi_i) begin
                    state <= IRQ_RAISED;
                end else begin
                    lost_o <= 1'b1;
                end
            end
        end
    end

endmodule

/* xgio.f */
+incdir+common
common/xgio_pkg.sv
src/io_decode.sv
src/io_execute.sv
timer/tick_timer.sv
kbd/kbd_fifo.sv
src/io_result.sv
src/xgio_top.sv
tb/tb_xgio.sv
